/* src/csr_settings.svh */
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Hart number reported by mhartid
`define CSR_HARTID 32'd0

// misa: MXL=1 (RV32), I base (bit 8), U mode (bit 20)
`define CSR_MISA 32'h4010_0100

// Trap base after reset
// Low two bits must stay zero, direct mode only
`define CSR_MTVEC_RESET 32'h0000_0100

// Width of cycle and instret
// Split into lo/hi halves of 32 bits each
`define CSR_CNT_W 64

`endif

/* src/csr_cmd_pkg.sv */
package csr_cmd_pkg;

    // One command per cycle from the pipeline
    typedef enum logic [3:0] {
        CSR_CMD_NONE            = 4'd0,
        CSR_CMD_WRITE           = 4'd1,
        CSR_CMD_READ            = 4'd2,
        CSR_CMD_READ_WRITE      = 4'd3,
        CSR_CMD_READ_SET        = 4'd4,
        CSR_CMD_READ_CLEAR      = 4'd5,
        CSR_CMD_MRET            = 4'd6,
        CSR_CMD_INTERRUPT_BEGIN = 4'd7,
        CSR_CMD_EXCEPTION_BEGIN = 4'd8
    } csr_cmd_t;

    // Machine and user only, no supervisor
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_t;

    // Commands that return the old CSR value
    function automatic logic cmd_is_read(input csr_cmd_t cmd);
        return cmd inside {CSR_CMD_READ, CSR_CMD_READ_WRITE,
                           CSR_CMD_READ_SET, CSR_CMD_READ_CLEAR};
    endfunction

    // Commands that update the CSR
    function automatic logic cmd_is_write(input csr_cmd_t cmd);
        return cmd inside {CSR_CMD_WRITE, CSR_CMD_READ_WRITE,
                           CSR_CMD_READ_SET, CSR_CMD_READ_CLEAR};
    endfunction

endpackage

/* src/csr_map_pkg.sv */
package csr_map_pkg;

    typedef logic [11:0] csr_addr_t;

    // Machine information and trap setup
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    // Trap handling
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MIP       = 12'h344;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;
    // Machine counters, writable
    localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
    localparam csr_addr_t CSR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t CSR_MINSTRETH = 12'hB82;
    // User counter aliases, read only
    localparam csr_addr_t CSR_CYCLE     = 12'hC00;
    localparam csr_addr_t CSR_INSTRET   = 12'hC02;
    localparam csr_addr_t CSR_CYCLEH    = 12'hC80;
    localparam csr_addr_t CSR_INSTRETH  = 12'hC82;

    // mstatus as seen by software, unused fields read zero
    typedef struct packed {
        logic [18:0] rsvd_31_13;
        logic [1:0]  mpp;         // Previous privilege
        logic [2:0]  rsvd_10_8;
        logic        mpie;        // Saved MIE
        logic [2:0]  rsvd_6_4;
        logic        mie;         // Global enable
        logic [2:0]  rsvd_2_0;
    } mstatus_t;

    // Same positions in mie and mip
    localparam int IRQ_MEI_BIT = 11;
    localparam int IRQ_MTI_BIT = 7;

    // Pack external and timer bits into an mie/mip word
    function automatic logic [31:0] irq_word(input logic mei, input logic mti);
        logic [31:0] w;
        w = '0;
        w[IRQ_MEI_BIT] = mei;
        w[IRQ_MTI_BIT] = mti;
        return w;
    endfunction

endpackage

/* src/csr_access_if.sv */
`timescale 1ns/1ps

// One bank of CSR storage as seen by the decoder
interface csr_access_if import csr_map_pkg::*; ();

    csr_addr_t   addr;        // Shared by all banks
    logic        write_en;    // Already qualified by validity
    logic [31:0] write_data;  // Final value after set/clear
    logic        hit;         // Bank owns addr
    logic        read_only;   // Owned but not writable
    logic [31:0] read_data;

    modport decoder (
        output addr,
        output write_en,
        output write_data,
        input  hit,
        input  read_only,
        input  read_data
    );

    modport bank (
        input  addr,
        input  write_en,
        input  write_data,
        output hit,
        output read_only,
        output read_data
    );

endinterface

/* src/csr_access.sv */
`timescale 1ns/1ps

module csr_access import csr_cmd_pkg::*, csr_map_pkg::*; (
    input  csr_cmd_t      cmd,
    input  csr_addr_t     addr,
    input  logic [31:0]   writedata,
    input  priv_t         priv,
    output logic [31:0]   readdata,
    output logic          invalid,
    output logic          trap_enter,  // Strobe to machine regs
    output logic          mret,        // Strobe, only when legal
    csr_access_if.decoder bank_m,
    csr_access_if.decoder bank_c
);

    logic        is_read;
    logic        is_write;
    logic [1:0]  priv_level;
    logic        any_hit;
    logic        ro_hit;
    logic        priv_fail;
    logic        access_bad;
    logic        mret_bad;
    logic [31:0] old_data;
    logic [31:0] new_data;

    assign is_read    = cmd_is_read(cmd);
    assign is_write   = cmd_is_write(cmd);
    assign priv_level = priv;

    // Bank responses
    assign any_hit = bank_m.hit | bank_c.hit;
    assign ro_hit  = (bank_m.hit & bank_m.read_only) | (bank_c.hit & bank_c.read_only);

    // Bits 9:8 hold the lowest privilege allowed to touch the CSR
    assign priv_fail = addr[9:8] > priv_level;

    always_comb begin
        access_bad = 1'b0;
        if (is_read || is_write) begin
            access_bad = !any_hit || priv_fail || (is_write && ro_hit);
        end
    end

    assign mret_bad = (cmd == CSR_CMD_MRET) && (priv != PRIV_M);  // No MRET from U
    assign invalid  = access_bad | mret_bad;

    // At most one bank hits
    always_comb begin
        if (bank_m.hit) begin
            old_data = bank_m.read_data;
        end else if (bank_c.hit) begin
            old_data = bank_c.read_data;
        end else begin
            old_data = '0;
        end
    end

    always_comb begin
        case (cmd)
            CSR_CMD_READ_SET:   new_data = old_data | writedata;
            CSR_CMD_READ_CLEAR: new_data = old_data & ~writedata;
            default:            new_data = writedata;  // WRITE, READ_WRITE
        endcase
    end

    // Nothing leaks out on a failed read
    assign readdata = (is_read && !access_bad) ? old_data : '0;

    // Same address and data to both banks, enable picks the owner
    assign bank_m.addr       = addr;
    assign bank_m.write_data = new_data;
    assign bank_m.write_en   = is_write && !access_bad && bank_m.hit;
    assign bank_c.addr       = addr;
    assign bank_c.write_data = new_data;
    assign bank_c.write_en   = is_write && !access_bad && bank_c.hit;

    // Traps are never rejected
    assign trap_enter = (cmd == CSR_CMD_INTERRUPT_BEGIN) || (cmd == CSR_CMD_EXCEPTION_BEGIN);
    assign mret       = (cmd == CSR_CMD_MRET) && !mret_bad;

endmodule

/* src/csr_machine_regs.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_machine_regs import csr_cmd_pkg::*, csr_map_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        trap_enter,
    input  logic        mret,
    input  logic [31:0] cause,
    input  logic [31:0] epc,
    input  logic        irq_external,
    input  logic        irq_timer,
    output priv_t       priv,
    output logic [31:0] next_pc,
    output logic        irq_pending,
    csr_access_if.bank  bank
);

    localparam logic [31:0] MTVEC_RESET_WORD = `CSR_MTVEC_RESET;

    priv_t       priv_q;
    logic        mstatus_mie;
    logic        mstatus_mpie;
    priv_t       mstatus_mpp;
    logic        mie_meie;
    logic        mie_mtie;
    logic [31:2] mtvec_base;   // Direct mode, low bits read zero
    logic [31:2] mepc_base;    // IALIGN 32
    logic [31:0] mscratch;
    logic [31:0] mcause;
    mstatus_t    mstatus_rd;
    mstatus_t    mstatus_wr;

    // Software view of mstatus
    always_comb begin
        mstatus_rd      = '0;
        mstatus_rd.mie  = mstatus_mie;
        mstatus_rd.mpie = mstatus_mpie;
        mstatus_rd.mpp  = mstatus_mpp;
    end

    assign mstatus_wr = bank.write_data;

    // Read side and address decode
    always_comb begin
        bank.hit       = 1'b1;
        bank.read_only = 1'b0;
        bank.read_data = '0;
        case (bank.addr)
            CSR_MSTATUS:  bank.read_data = mstatus_rd;
            CSR_MISA: begin
                bank.read_data = `CSR_MISA;
                bank.read_only = 1'b1;
            end
            CSR_MIE:      bank.read_data = irq_word(mie_meie, mie_mtie);
            CSR_MTVEC:    bank.read_data = {mtvec_base, 2'b00};
            CSR_MSCRATCH: bank.read_data = mscratch;
            CSR_MEPC:     bank.read_data = {mepc_base, 2'b00};
            CSR_MCAUSE:   bank.read_data = mcause;
            CSR_MIP:      bank.read_data = irq_word(irq_external, irq_timer);  // Wires only
            CSR_MHARTID: begin
                bank.read_data = `CSR_HARTID;
                bank.read_only = 1'b1;
            end
            default:      bank.hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            priv_q       <= PRIV_M;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= PRIV_U;
            mie_meie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mtvec_base   <= MTVEC_RESET_WORD[31:2];
            mepc_base    <= '0;
            mscratch     <= '0;
            mcause       <= '0;
        end else if (trap_enter) begin
            mepc_base    <= epc[31:2];
            mcause       <= cause;
            mstatus_mpie <= mstatus_mie;  // Stack the enable
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= priv_q;
            priv_q       <= PRIV_M;
        end else if (mret) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            priv_q       <= mstatus_mpp;
            mstatus_mpp  <= PRIV_U;       // Least privileged mode supported
        end else if (bank.write_en) begin
            case (bank.addr)
                CSR_MSTATUS: begin
                    mstatus_mie  <= mstatus_wr.mie;
                    mstatus_mpie <= mstatus_wr.mpie;
                    // WARL, anything but M falls back to U
                    mstatus_mpp  <= (mstatus_wr.mpp == 2'b11) ? PRIV_M : PRIV_U;
                end
                CSR_MIE: begin
                    mie_meie <= bank.write_data[IRQ_MEI_BIT];
                    mie_mtie <= bank.write_data[IRQ_MTI_BIT];
                end
                CSR_MTVEC:    mtvec_base <= bank.write_data[31:2];
                CSR_MSCRATCH: mscratch   <= bank.write_data;
                CSR_MEPC:     mepc_base  <= bank.write_data[31:2];
                CSR_MCAUSE:   mcause     <= bank.write_data;
                default: ;  // misa, mhartid, mip hold nothing writable
            endcase
        end
    end

    assign priv = priv_q;

    // Trap target while entering, return address otherwise
    assign next_pc = trap_enter ? {mtvec_base, 2'b00} : {mepc_base, 2'b00};

    assign irq_pending = mstatus_mie &
                         ((mie_meie & irq_external) | (mie_mtie & irq_timer));

endmodule

/* src/csr_counters.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_counters import csr_map_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       instret_inc,  // One retired instruction
    csr_access_if.bank bank
);

    logic [`CSR_CNT_W-1:0] cycle_q;
    logic [`CSR_CNT_W-1:0] instret_q;

    // Written half wins, otherwise count
    function automatic logic [`CSR_CNT_W-1:0] count_next(
        input logic [`CSR_CNT_W-1:0] cnt,
        input logic                  wr_lo,
        input logic                  wr_hi,
        input logic [31:0]           data,
        input logic                  inc
    );
        if (wr_lo) begin
            return {cnt[`CSR_CNT_W-1:32], data};
        end
        if (wr_hi) begin
            return {data, cnt[31:0]};
        end
        return inc ? cnt + `CSR_CNT_W'(1) : cnt;
    endfunction

    always_comb begin
        bank.hit       = 1'b1;
        bank.read_only = bank.addr[11:10] == 2'b11;  // User aliases
        case (bank.addr)
            CSR_MCYCLE, CSR_CYCLE:       bank.read_data = cycle_q[31:0];
            CSR_MCYCLEH, CSR_CYCLEH:     bank.read_data = cycle_q[`CSR_CNT_W-1:32];
            CSR_MINSTRET, CSR_INSTRET:   bank.read_data = instret_q[31:0];
            CSR_MINSTRETH, CSR_INSTRETH: bank.read_data = instret_q[`CSR_CNT_W-1:32];
            default: begin
                bank.hit       = 1'b0;
                bank.read_data = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_q   <= '0;
            instret_q <= '0;
        end else begin
            cycle_q   <= count_next(cycle_q, bank.write_en && bank.addr == CSR_MCYCLE,
                                    bank.write_en && bank.addr == CSR_MCYCLEH,
                                    bank.write_data, 1'b1);
            instret_q <= count_next(instret_q, bank.write_en && bank.addr == CSR_MINSTRET,
                                    bank.write_en && bank.addr == CSR_MINSTRETH,
                                    bank.write_data, instret_inc);
        end
    end

endmodule

/* src/csr_top.sv */
`timescale 1ns/1ps

module csr_top import csr_cmd_pkg::*, csr_map_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  csr_cmd_t    csr_cmd,
    input  csr_addr_t   csr_address,
    input  logic [31:0] csr_writedata,
    input  logic [31:0] csr_exc_cause,    // mcause on trap entry
    input  logic [31:0] csr_exc_epc,      // Faulting or interrupted pc
    input  logic        irq_external,
    input  logic        irq_timer,
    input  logic        instret_inc,
    output logic [31:0] csr_readdata,
    output logic        csr_invalid,
    output logic [31:0] csr_next_pc,
    output priv_t       csr_priv,
    output logic        csr_irq_pending
);

    logic trap_enter;
    logic mret;

    // Machine registers and counters
    csr_access_if bank_m ();
    csr_access_if bank_c ();

    csr_access u_access (
        .cmd        (csr_cmd),
        .addr       (csr_address),
        .writedata  (csr_writedata),
        .priv       (csr_priv),          // Current mode for the access check
        .readdata   (csr_readdata),
        .invalid    (csr_invalid),
        .trap_enter (trap_enter),
        .mret       (mret),
        .bank_m     (bank_m),
        .bank_c     (bank_c)
    );

    csr_machine_regs u_machine_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .trap_enter   (trap_enter),
        .mret         (mret),
        .cause        (csr_exc_cause),
        .epc          (csr_exc_epc),
        .irq_external (irq_external),
        .irq_timer    (irq_timer),
        .priv         (csr_priv),
        .next_pc      (csr_next_pc),
        .irq_pending  (csr_irq_pending),
        .bank         (bank_m)
    );

    csr_counters u_counters (
        .clk         (clk),
        .rst_n       (rst_n),
        .instret_inc (instret_inc),
        .bank        (bank_c)
    );

endmodule

/* bench/csr_clock_gen.sv */
`timescale 1ns/1ps

// Free-running clock plus a synchronous active-low reset
module csr_clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // Released just after an edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

/* bench/csr_tb.sv */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_tb import csr_cmd_pkg::*, csr_map_pkg::*; ();

    // Stimulus first, expected outputs after
    typedef struct packed {
        csr_cmd_t    cmd;
        csr_addr_t   addr;
        logic [31:0] wdata;
        logic [31:0] cause;
        logic [31:0] epc;
        logic        tmr;
        logic        inc;
        logic [31:0] exp_rd;
        logic        chk_rd;    // Successful reads only
        logic        exp_inv;
        priv_t       exp_priv;
        logic [31:0] exp_pc;
        logic        chk_pc;    // Trap and MRET rows
        logic        exp_pend;
    } row_t;

    logic        clk;
    logic        rst_n;
    csr_cmd_t    csr_cmd;
    csr_addr_t   csr_address;
    logic [31:0] csr_writedata;
    logic [31:0] csr_exc_cause;
    logic [31:0] csr_exc_epc;
    logic        irq_external;
    logic        irq_timer;
    logic        instret_inc;
    logic [31:0] csr_readdata;
    logic        csr_invalid;
    logic [31:0] csr_next_pc;
    priv_t       csr_priv;
    logic        csr_irq_pending;

    row_t        rows[$];
    string       row_names[$];
    logic [31:0] lfsr_q = 32'h59743d50;
    int          error_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;  // Replaced once the table is known

    // Stimulus held across rows and the reference model of the registers
    logic [31:0] st_cause;
    logic [31:0] st_epc;
    logic        st_tmr;
    logic        st_inc;
    priv_t       m_priv;
    logic        m_pend;
    logic [31:0] m_mtvec;
    logic [31:0] m_mepc;

    csr_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

    csr_top u_csr_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .csr_cmd         (csr_cmd),
        .csr_address     (csr_address),
        .csr_writedata   (csr_writedata),
        .csr_exc_cause   (csr_exc_cause),
        .csr_exc_epc     (csr_exc_epc),
        .irq_external    (irq_external),
        .irq_timer       (irq_timer),
        .instret_inc     (instret_inc),
        .csr_readdata    (csr_readdata),
        .csr_invalid     (csr_invalid),
        .csr_next_pc     (csr_next_pc),
        .csr_priv        (csr_priv),
        .csr_irq_pending (csr_irq_pending)
    );

    // Right-shifting Galois form, taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            w[i]   = lfsr_q[0];  // One step per bit
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    // MIE bit 3, MPIE bit 7, MPP bits 12:11
    function automatic logic [31:0] status_word(input logic mie, input logic mpie,
                                                input logic [1:0] mpp);
        return {19'b0, mpp, 3'b0, mpie, 3'b0, mie, 3'b0};
    endfunction

    task automatic report_failure();
        $display("Done: errors found");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            error_count++;
            report_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
            error_count++;
            report_failure();
        end
    endtask

    task automatic check_priv(input string name, input priv_t exp, input priv_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
            error_count++;
            report_failure();
        end
    endtask

    task automatic add_row(input string name, input csr_cmd_t cmd, input csr_addr_t addr,
                           input logic [31:0] wdata, input logic [31:0] exp_rd,
                           input logic exp_inv);
        row_t r;
        r          = '0;
        r.cmd      = cmd;
        r.addr     = addr;
        r.wdata    = wdata;
        r.cause    = st_cause;
        r.epc      = st_epc;
        r.tmr      = st_tmr;
        r.inc      = st_inc;
        r.exp_rd   = exp_rd;
        r.exp_inv  = exp_inv;
        r.chk_rd   = !exp_inv && (cmd inside {CSR_CMD_READ, CSR_CMD_READ_WRITE,
                                              CSR_CMD_READ_SET, CSR_CMD_READ_CLEAR});
        r.exp_priv = m_priv;
        r.exp_pend = m_pend;
        r.exp_pc   = (cmd == CSR_CMD_MRET) ? m_mepc : m_mtvec;  // Trap goes to mtvec
        r.chk_pc   = !exp_inv && (cmd inside {CSR_CMD_MRET, CSR_CMD_INTERRUPT_BEGIN,
                                              CSR_CMD_EXCEPTION_BEGIN});
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] s;
        logic [31:0] instret_model;
        logic [7:0]  inc_pattern;
        st_cause = '0;
        st_epc   = '0;
        st_tmr   = 1'b0;
        st_inc   = 1'b0;
        m_priv   = PRIV_M;
        m_pend   = 1'b0;
        m_mtvec  = `CSR_MTVEC_RESET;
        m_mepc   = '0;
        add_row("reset mtvec", CSR_CMD_READ, CSR_MTVEC, 0, `CSR_MTVEC_RESET, 0);
        add_row("reset misa", CSR_CMD_READ, CSR_MISA, 0, `CSR_MISA, 0);
        add_row("reset mhartid", CSR_CMD_READ, CSR_MHARTID, 0, `CSR_HARTID, 0);
        add_row("reset mscratch", CSR_CMD_READ, CSR_MSCRATCH, 0, 0, 0);
        add_row("reset mstatus", CSR_CMD_READ, CSR_MSTATUS, 0, 0, 0);
        // mscratch with random data
        random_word(s);
        add_row("scratch write", CSR_CMD_WRITE, CSR_MSCRATCH, s, 0, 0);
        add_row("scratch read", CSR_CMD_READ, CSR_MSCRATCH, 0, s, 0);
        random_word(a);
        add_row("scratch set", CSR_CMD_READ_SET, CSR_MSCRATCH, a, s, 0);
        s = s | a;
        add_row("scratch after set", CSR_CMD_READ, CSR_MSCRATCH, 0, s, 0);
        random_word(a);
        add_row("scratch clear", CSR_CMD_READ_CLEAR, CSR_MSCRATCH, a, s, 0);
        s = s & ~a;
        add_row("scratch after clear", CSR_CMD_READ, CSR_MSCRATCH, 0, s, 0);
        random_word(a);
        add_row("scratch swap", CSR_CMD_READ_WRITE, CSR_MSCRATCH, a, s, 0);
        s = a;
        add_row("hartid write", CSR_CMD_WRITE, CSR_MHARTID, 32'h1234, 0, 1);
        add_row("hartid kept", CSR_CMD_READ, CSR_MHARTID, 0, `CSR_HARTID, 0);
        add_row("cycle alias write", CSR_CMD_WRITE, CSR_CYCLE, 32'hFFFF, 0, 1);
        // Row i sees i+1 counting edges since reset release
        add_row("cycle kept", CSR_CMD_READ, CSR_CYCLE, 0, rows.size() + 1, 0);
        add_row("scratch kept", CSR_CMD_READ, CSR_MSCRATCH, 0, s, 0);
        add_row("unknown csr", CSR_CMD_READ, 12'h7C0, 0, 0, 1);
        // Exception entry from machine mode
        add_row("mtvec write", CSR_CMD_WRITE, CSR_MTVEC, 32'h1000_0403, 0, 0);
        m_mtvec = 32'h1000_0400;  // Low bits dropped
        add_row("mtvec read", CSR_CMD_READ, CSR_MTVEC, 0, m_mtvec, 0);
        add_row("enable mie", CSR_CMD_WRITE, CSR_MSTATUS, status_word(1, 0, 2'b00), 0, 0);
        st_cause = 32'd2;
        st_epc   = 32'h0000_1236;
        add_row("exception", CSR_CMD_EXCEPTION_BEGIN, 0, 0, 0, 0);
        m_mepc   = 32'h0000_1234;
        add_row("mcause", CSR_CMD_READ, CSR_MCAUSE, 0, 32'd2, 0);
        add_row("mepc", CSR_CMD_READ, CSR_MEPC, 0, m_mepc, 0);
        add_row("trap mstatus", CSR_CMD_READ, CSR_MSTATUS, 0, status_word(0, 1, 2'b11), 0);
        // Return to user mode
        add_row("mpp to user", CSR_CMD_WRITE, CSR_MSTATUS, status_word(0, 1, 2'b00), 0, 0);
        add_row("mret", CSR_CMD_MRET, 0, 0, 0, 0);
        m_priv = PRIV_U;
        add_row("user mscratch", CSR_CMD_READ, CSR_MSCRATCH, 0, 0, 1);
        add_row("user cycleh", CSR_CMD_READ, CSR_CYCLEH, 0, 0, 0);  // Short run, high half 0
        add_row("user mret", CSR_CMD_MRET, 0, 0, 0, 1);
        st_cause = 32'd8;
        st_epc   = 32'h0000_2000;
        add_row("ecall from user", CSR_CMD_EXCEPTION_BEGIN, 0, 0, 0, 0);
        m_priv   = PRIV_M;
        m_mepc   = 32'h0000_2000;
        add_row("user trap mstatus", CSR_CMD_READ, CSR_MSTATUS, 0,
                status_word(0, 1, 2'b00), 0);
        // Timer interrupt
        add_row("enable mtie", CSR_CMD_WRITE, CSR_MIE, 32'h0000_0080, 0, 0);
        add_row("enable mie again", CSR_CMD_WRITE, CSR_MSTATUS, status_word(1, 1, 2'b00), 0, 0);
        st_tmr = 1'b1;
        m_pend = 1'b1;
        add_row("timer pending", CSR_CMD_READ, CSR_MIP, 0, 32'h0000_0080, 0);
        add_row("clear mtie", CSR_CMD_READ_CLEAR, CSR_MIE, 32'h80, 32'h80, 0);
        m_pend = 1'b0;  // Drops once MTIE is gone
        add_row("mtie cleared", CSR_CMD_READ, CSR_MIE, 0, 0, 0);
        st_tmr   = 1'b0;
        st_cause = 32'h8000_0007;
        st_epc   = 32'h0000_3000;
        add_row("interrupt", CSR_CMD_INTERRUPT_BEGIN, 0, 0, 0, 0);
        st_cause = '0;
        st_epc   = '0;
        add_row("interrupt mcause", CSR_CMD_READ, CSR_MCAUSE, 0, 32'h8000_0007, 0);
        // Counters
        add_row("mcycle write", CSR_CMD_WRITE, CSR_MCYCLE, 32'h0000_5000, 0, 0);
        add_row("mcycle w", CSR_CMD_READ, CSR_MCYCLE, 0, 32'h0000_5000, 0);
        add_row("mcycle w+1", CSR_CMD_READ, CSR_MCYCLE, 0, 32'h0000_5001, 0);
        st_inc = 1'b1;  // Write wins over the increment
        add_row("minstret write", CSR_CMD_WRITE, CSR_MINSTRET, 32'h0000_0100, 0, 0);
        instret_model = 32'h0000_0100;
        inc_pattern   = 8'b1011_0010;
        for (int i = 0; i < 8; i++) begin
            st_inc = inc_pattern[i];
            add_row("minstret count", CSR_CMD_READ, CSR_MINSTRET, 0, instret_model, 0);
            instret_model = instret_model + {31'b0, st_inc};
        end
        st_inc = 1'b0;
        add_row("instret final", CSR_CMD_READ, CSR_INSTRET, 0, instret_model, 0);
    endtask

    task automatic apply_row(input row_t r);
        csr_cmd       = r.cmd;
        csr_address   = r.addr;
        csr_writedata = r.wdata;
        csr_exc_cause = r.cause;
        csr_exc_epc   = r.epc;
        irq_timer     = r.tmr;
        instret_inc   = r.inc;
    endtask

    task automatic check_row(input string name, input row_t r);
        if (r.chk_rd) begin
            check_word({name, " readdata"}, r.exp_rd, csr_readdata);
        end
        check_flag({name, " invalid"}, r.exp_inv, csr_invalid);
        check_priv({name, " priv"}, r.exp_priv, csr_priv);
        if (r.chk_pc) begin
            check_word({name, " next_pc"}, r.exp_pc, csr_next_pc);
        end
        check_flag({name, " irq_pending"}, r.exp_pend, csr_irq_pending);
    endtask

    // Run limit, reset included
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: test did not finish within %0d cycles", cycle_limit);
            report_failure();
        end
    end

    initial begin
        csr_cmd       = CSR_CMD_NONE;
        csr_address   = '0;
        csr_writedata = '0;
        csr_exc_cause = '0;
        csr_exc_epc   = '0;
        irq_external  = 1'b0;  // External line stays idle
        irq_timer     = 1'b0;
        instret_inc   = 1'b0;
        build_table();
        cycle_limit = 8 + 4 * rows.size() + 20;
        wait (rst_n === 1'b1);
        foreach (rows[i]) begin
            @(posedge clk);
            #1;
            apply_row(rows[i]);
            #8;  // Just before the next edge
            check_row(row_names[i], rows[i]);
        end
        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            report_failure();
        end
    end

endmodule

/* all.f */
+incdir+src
src/csr_cmd_pkg.sv
src/csr_map_pkg.sv
src/csr_access_if.sv
src/csr_access.sv
src/csr_machine_regs.sv
src/csr_counters.sv
src/csr_top.sv
bench/csr_clock_gen.sv
bench/csr_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f all.f --top-module csr_tb -Mdir obj_dir -o csr_sim
obj_dir/csr_sim 2>&1 | tee "$LOG"

if grep -q "Done: no errors" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi
